// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_pet_kbd
FILE_LIST := src.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/kbd_ctrl_regs.sv ====
`timescale 1ns/1ps

module kbd_ctrl_regs (
    input  logic                 wb_clock_i,
    input  logic                 arst_n_i,
    input  pet_kbd_pkg::wb_req_t wb_req_i,
    output pet_kbd_pkg::wb_rsp_t wb_rsp_o,
    input  logic [3:0]           sel_row_i,            // Row latched by the snoop
    output logic                 intercept_en_o
);
    import pet_kbd_pkg::*;

    logic [KBD_OFFSET_WIDTH-1:0] offset;
    logic                        is_ctrl;
    logic                        is_row;
    logic                        wb_req;
    logic                        wb_take;
    logic                        ack_q;
    logic                        acked;
    logic                        en_q;
    logic [DATA_WIDTH-1:0]       rd_dat_q;
    logic [DATA_WIDTH-1:0]       rd_mux;

    assign offset  = wb_req_i.adr[KBD_OFFSET_WIDTH-1:0];
    assign is_ctrl = offset == REG_CTRL;
    assign is_row  = offset == REG_ROW;
    assign wb_req  = wb_req_i.cyc && wb_req_i.stb;
    assign wb_take = wb_req && !ack_q && !acked;

    // Read view, unused CTRL bits are 0
    always_comb begin
        if (is_ctrl) begin
            rd_mux = {{(DATA_WIDTH-1){1'b0}}, en_q};
        end else if (is_row) begin
            rd_mux = {{(DATA_WIDTH-KBD_ADDR_WIDTH){1'b0}}, sel_row_i};
        end else begin
            rd_mux = 8'hFF;
        end
    end

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            acked <= 1'b0;
            en_q  <= 1'b1;                             // Intercept on out of reset
        end else begin
            ack_q <= wb_take;
            acked <= wb_req && (ack_q || acked);
            if (wb_take && wb_req_i.we && is_ctrl) begin
                en_q <= wb_req_i.dat[0];
            end
            // ROW writes are acked and dropped
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (wb_take) begin
            rd_dat_q <= rd_mux;
        end
    end

    assign wb_rsp_o.dat   = rd_dat_q;
    assign wb_rsp_o.ack   = ack_q;
    assign intercept_en_o = en_q;

endmodule

// ==== hw/kbd_matrix.sv ====
`timescale 1ns/1ps

module kbd_matrix #(
    parameter int ROW_COUNT = 10
) (
    input  logic                 wb_clock_i,
    input  logic                 arst_n_i,
    input  pet_kbd_pkg::wb_req_t wb_req_i,
    output pet_kbd_pkg::wb_rsp_t wb_rsp_o,
    input  logic [3:0]           row_sel_i,            // Row the CPU has selected
    output logic [7:0]           row_data_o            // Registered, one cycle behind row_sel_i
);
    import pet_kbd_pkg::*;

    // One extra bit so that 16 rows still compare correctly
    localparam logic [KBD_ADDR_WIDTH:0] ROW_LIMIT = (KBD_ADDR_WIDTH + 1)'(ROW_COUNT);

    // PET matrix is active low, 0 means pressed
    logic [DATA_WIDTH-1:0]     rows [ROW_COUNT];
    logic [KBD_ADDR_WIDTH-1:0] wb_idx;
    logic                      wb_idx_ok;
    logic                      cpu_idx_ok;
    logic                      wb_req;
    logic                      wb_take;              // First cycle of a new access
    logic                      ack_q;
    logic                      acked;
    logic [DATA_WIDTH-1:0]     rd_dat_q;
    logic [DATA_WIDTH-1:0]     row_q;

    assign wb_idx     = wb_req_i.adr[KBD_ADDR_WIDTH-1:0];
    assign wb_idx_ok  = {1'b0, wb_idx} < ROW_LIMIT;
    assign cpu_idx_ok = {1'b0, row_sel_i} < ROW_LIMIT;
    assign wb_req     = wb_req_i.cyc && wb_req_i.stb;
    assign wb_take    = wb_req && !ack_q && !acked;

    // Storage and handshake
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < ROW_COUNT; i++) begin
                rows[i] <= 8'hFF;                      // No keys pressed
            end
            ack_q <= 1'b0;
            acked <= 1'b0;
        end else begin
            ack_q <= wb_take;
            acked <= wb_req && (ack_q || acked);
            if (wb_take && wb_req_i.we && wb_idx_ok) begin
                rows[wb_idx] <= wb_req_i.dat;          // Rows past ROW_COUNT drop the write
            end
        end
    end

    // Read data for Wishbone, valid with ack
    always_ff @(posedge wb_clock_i) begin
        if (wb_take) begin
            rd_dat_q <= wb_idx_ok ? rows[wb_idx] : 8'hFF;
        end
    end

    // CPU lookup runs every cycle
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_q <= 8'hFF;
        end else begin
            row_q <= cpu_idx_ok ? rows[row_sel_i] : 8'hFF;   // Missing rows look idle
        end
    end

    assign wb_rsp_o.dat = rd_dat_q;
    assign wb_rsp_o.ack = ack_q;
    assign row_data_o   = row_q;

    // A held strobe must not be acked twice in a row
    a_ack_single: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        (wb_req && $past(wb_req && ack_q)) |=> !ack_q);

endmodule

// ==== hw/pet_kbd_pkg.sv ====
package pet_kbd_pkg;

    // Bus widths
    localparam int DATA_WIDTH       = 8;
    localparam int WB_ADDR_WIDTH    = 16;
    localparam int KBD_ADDR_WIDTH   = 4;                 // Row index, up to 16 rows
    localparam int KBD_OFFSET_WIDTH = 8;                 // Low address bits inside the window
    localparam int PIA_RS_WIDTH     = 2;

    // Keyboard window in Wishbone space
    localparam logic [WB_ADDR_WIDTH-1:0]    KBD_BASE = 16'hE800;
    localparam logic [KBD_OFFSET_WIDTH-1:0] REG_CTRL = 8'h10;   // Bit 0 intercept enable
    localparam logic [KBD_OFFSET_WIDTH-1:0] REG_ROW  = 8'h11;   // Selected row, read-only

    // PIA register numbers as seen on cpu_addr[1:0]
    localparam logic [PIA_RS_WIDTH-1:0] PIA_PORTA = 2'd0;  // Row select
    localparam logic [PIA_RS_WIDTH-1:0] PIA_PORTB = 2'd2;  // Row data

    // Wishbone classic request, 27 bits
    typedef struct packed {
        logic [WB_ADDR_WIDTH-1:0] adr;
        logic [DATA_WIDTH-1:0]    dat;
        logic                     we;
        logic                     cyc;
        logic                     stb;
    } wb_req_t;

    // Wishbone response, 9 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0] dat;
        logic                  ack;
    } wb_rsp_t;

    // CPU side of PIA 1 with chip select already decoded, 14 bits
    typedef struct packed {
        logic [PIA_RS_WIDTH-1:0] rs;
        logic                    cs;
        logic                    we;
        logic [DATA_WIDTH-1:0]   dat;
        logic                    valid;                // Address and control are stable
        logic                    done;                 // Last cycle of the bus access
    } cpu_bus_t;

endpackage

// ==== hw/pet_kbd_top.sv ====
`timescale 1ns/1ps

module pet_kbd_top #(
    parameter int ROW_COUNT = 10
) (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,
    input  pet_kbd_pkg::wb_req_t  wb_req_i,
    output pet_kbd_pkg::wb_rsp_t  wb_rsp_o,
    input  pet_kbd_pkg::cpu_bus_t cpu_i,
    output logic [7:0]            cpu_data_o,
    output logic                  cpu_data_oe_o
);
    import pet_kbd_pkg::*;

    wb_req_t                   mtx_req;
    wb_rsp_t                   mtx_rsp;
    wb_req_t                   reg_req;
    wb_rsp_t                   reg_rsp;
    logic [KBD_ADDR_WIDTH-1:0] row_sel;                // Snoop to matrix
    logic [DATA_WIDTH-1:0]     row_data;               // Matrix to snoop
    logic [KBD_ADDR_WIDTH-1:0] sel_row;                // Snoop to ROW register
    logic                      intercept_en;

    wb_periph_mux u_mux (
        .wb_clock_i (wb_clock_i),
        .arst_n_i   (arst_n_i),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .mtx_req_o  (mtx_req),
        .mtx_rsp_i  (mtx_rsp),
        .reg_req_o  (reg_req),
        .reg_rsp_i  (reg_rsp)
    );

    kbd_matrix #(.ROW_COUNT(ROW_COUNT)) u_matrix (
        .wb_clock_i (wb_clock_i),
        .arst_n_i   (arst_n_i),
        .wb_req_i   (mtx_req),
        .wb_rsp_o   (mtx_rsp),
        .row_sel_i  (row_sel),
        .row_data_o (row_data)
    );

    kbd_ctrl_regs u_regs (
        .wb_clock_i     (wb_clock_i),
        .arst_n_i       (arst_n_i),
        .wb_req_i       (reg_req),
        .wb_rsp_o       (reg_rsp),
        .sel_row_i      (sel_row),
        .intercept_en_o (intercept_en)
    );

    pia_kbd_snoop #(.ROW_COUNT(ROW_COUNT)) u_snoop (
        .wb_clock_i     (wb_clock_i),
        .arst_n_i       (arst_n_i),
        .cpu_i          (cpu_i),
        .intercept_en_i (intercept_en),
        .row_sel_o      (row_sel),
        .row_data_i     (row_data),
        .sel_row_o      (sel_row),
        .cpu_data_o     (cpu_data_o),
        .cpu_data_oe_o  (cpu_data_oe_o)
    );

endmodule

// ==== hw/pia_kbd_snoop.sv ====
`timescale 1ns/1ps

module pia_kbd_snoop #(
    parameter int ROW_COUNT = 10
) (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,
    input  pet_kbd_pkg::cpu_bus_t cpu_i,
    input  logic                  intercept_en_i,
    output logic [3:0]            row_sel_o,           // To matrix lookup
    input  logic [7:0]            row_data_i,          // One cycle after row_sel_o
    output logic [3:0]            sel_row_o,           // To ROW register
    output logic [7:0]            cpu_data_o,
    output logic                  cpu_data_oe_o
);
    import pet_kbd_pkg::*;

    localparam logic [KBD_ADDR_WIDTH:0] ROW_LIMIT = (KBD_ADDR_WIDTH + 1)'(ROW_COUNT);

    logic                      wr_porta;               // CPU selects next row
    logic                      rd_portb;               // CPU reads current row
    logic [KBD_ADDR_WIDTH-1:0] sel_row_q;
    logic                      lookup_q;               // Matrix read in flight
    logic                      oe_q;
    logic [DATA_WIDTH-1:0]     data_q;
    logic                      row_ok;
    logic                      pressed;

    assign wr_porta =  cpu_i.we && cpu_i.cs && (cpu_i.rs == PIA_PORTA);
    assign rd_portb = !cpu_i.we && cpu_i.cs && (cpu_i.rs == PIA_PORTB);

    assign row_ok  = {1'b0, sel_row_q} < ROW_LIMIT;
    assign pressed = row_data_i != 8'hFF;              // At least one key down

    // Row select and intercept control
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_row_q <= '0;
            lookup_q  <= 1'b0;
            oe_q      <= 1'b0;
        end else begin
            if (wr_porta && cpu_i.done) begin
                sel_row_q <= cpu_i.dat[KBD_ADDR_WIDTH-1:0];
            end

            if (cpu_i.done) begin
                lookup_q <= 1'b0;
                oe_q     <= 1'b0;                      // Release bus after the access
            end else if (lookup_q) begin
                lookup_q <= 1'b0;
                oe_q     <= intercept_en_i && row_ok && pressed;
            end else if (rd_portb && cpu_i.valid) begin
                lookup_q <= 1'b1;                      // Matrix samples the row this edge
            end
        end
    end

    // Row contents captured with the intercept decision
    always_ff @(posedge wb_clock_i) begin
        if (lookup_q) begin
            data_q <= row_data_i;
        end
    end

    assign row_sel_o     = sel_row_q;
    assign sel_row_o     = sel_row_q;
    assign cpu_data_o    = data_q;
    assign cpu_data_oe_o = oe_q;

    // Driving the data bus during a CPU write would fight the CPU
    a_no_oe_on_write: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        cpu_data_oe_o |-> !cpu_i.we);

endmodule

// ==== hw/wb_periph_mux.sv ====
`timescale 1ns/1ps

module wb_periph_mux (
    input  logic                 wb_clock_i,
    input  logic                 arst_n_i,
    input  pet_kbd_pkg::wb_req_t wb_req_i,
    output pet_kbd_pkg::wb_rsp_t wb_rsp_o,
    output pet_kbd_pkg::wb_req_t mtx_req_o,
    input  pet_kbd_pkg::wb_rsp_t mtx_rsp_i,
    output pet_kbd_pkg::wb_req_t reg_req_o,
    input  pet_kbd_pkg::wb_rsp_t reg_rsp_i
);
    import pet_kbd_pkg::*;

    logic [KBD_OFFSET_WIDTH-1:0] offset;
    logic                        in_window;
    logic                        sel_mtx;
    logic                        sel_reg;
    logic                        unm_req;              // Live request nobody owns
    logic                        unm_ack;
    logic                        unm_acked;            // Ack already given for this strobe

    assign offset    = wb_req_i.adr[KBD_OFFSET_WIDTH-1:0];
    assign in_window = wb_req_i.adr[WB_ADDR_WIDTH-1:KBD_OFFSET_WIDTH]
                       == KBD_BASE[WB_ADDR_WIDTH-1:KBD_OFFSET_WIDTH];

    // Rows sit at offsets 0x00-0x0F
    assign sel_mtx = in_window && (offset[KBD_OFFSET_WIDTH-1:KBD_ADDR_WIDTH] == '0);
    assign sel_reg = in_window && ((offset == REG_CTRL) || (offset == REG_ROW));
    assign unm_req = wb_req_i.cyc && wb_req_i.stb && !sel_mtx && !sel_reg;

    // Forward the request, strobe only to the owner
    always_comb begin
        mtx_req_o     = wb_req_i;
        mtx_req_o.stb = wb_req_i.stb && sel_mtx;
        reg_req_o     = wb_req_i;
        reg_req_o.stb = wb_req_i.stb && sel_reg;
    end

    // Unmapped space answers on its own, one ack per strobe
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            unm_ack   <= 1'b0;
            unm_acked <= 1'b0;
        end else begin
            unm_ack   <= unm_req && !unm_ack && !unm_acked;
            unm_acked <= unm_req && (unm_ack || unm_acked);  // Cleared once stb drops
        end
    end

    // Address is held until ack, so select is stable for the return path
    always_comb begin
        if (sel_mtx) begin
            wb_rsp_o = mtx_rsp_i;
        end else if (sel_reg) begin
            wb_rsp_o = reg_rsp_i;
        end else begin
            wb_rsp_o.dat = 8'hFF;                      // Open bus
            wb_rsp_o.ack = unm_ack;
        end
    end

    // Only one responder may own a cycle
    a_one_responder: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        !(mtx_rsp_i.ack && reg_rsp_i.ack));

endmodule

// ==== src.f ====
hw/pet_kbd_pkg.sv
hw/wb_periph_mux.sv
hw/kbd_matrix.sv
hw/kbd_ctrl_regs.sv
hw/pia_kbd_snoop.sv
hw/pet_kbd_top.sv
test/tb_pet_kbd.sv

// ==== test/tb_pet_kbd.sv ====
`timescale 1ns/1ps

module tb_pet_kbd;
    import pet_kbd_pkg::*;

    localparam int ROW_COUNT   = 10;
    localparam int ACK_TIMEOUT = 20;                   // Cycles to wait for a Wishbone ack

    logic       wb_clock = 1'b0;
    logic       arst_n;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    cpu_bus_t   cpu;
    logic [7:0] cpu_data;
    logic       cpu_data_oe;

    // Reference state, mirrors every Wishbone write and port A write
    logic [7:0] model [16];
    logic [3:0] exp_sel;
    logic       exp_en;
    logic       exp_hit;                               // Port B read should be intercepted
    logic [7:0] exp_row;
    logic       rd_open;                               // A port B read is in flight
    logic       rd_strobe;
    logic [31:0] rng = 32'd51;
    int         ack_count = 0;

    pet_kbd_top #(.ROW_COUNT(ROW_COUNT)) UUT (
        .wb_clock_i    (wb_clock),
        .arst_n_i      (arst_n),
        .wb_req_i      (wb_req),
        .wb_rsp_o      (wb_rsp),
        .cpu_i         (cpu),
        .cpu_data_o    (cpu_data),
        .cpu_data_oe_o (cpu_data_oe)
    );

    always #4 wb_clock = ~wb_clock;                    // 8 ns period

    always @(posedge wb_clock) begin
        if (wb_rsp.ack) begin
            ack_count <= ack_count + 1;
        end
    end

    assign exp_row   = model[exp_sel];
    assign exp_hit   = exp_en && ({1'b0, exp_sel} < 5'(ROW_COUNT)) && (exp_row != 8'hFF);
    assign rd_strobe = cpu.valid && cpu.cs && !cpu.we && (cpu.rs == PIA_PORTB);

    task automatic abort_with(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [7:0] exp, input logic [7:0] act);
        abort_with($sformatf("[FAIL] %s: expected 0x%02h, actual 0x%02h", name, exp, act));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Intercept shows two cycles after the port B valid strobe
    a_intercept_rise: assert property (@(posedge wb_clock) disable iff (!arst_n)
        $past(rd_strobe, 2) |-> (cpu_data_oe == exp_hit))
        else mismatch("intercept after port B read", 8'(exp_hit), 8'(cpu_data_oe));

    a_intercept_data: assert property (@(posedge wb_clock) disable iff (!arst_n)
        cpu_data_oe |-> (cpu_data == exp_row))
        else mismatch("intercepted row data", exp_row, cpu_data);

    a_no_stray_oe: assert property (@(posedge wb_clock) disable iff (!arst_n)
        cpu_data_oe |-> (rd_open && exp_hit))
        else abort_with("cpu_data_oe_o went high outside an intercepted port B read");

    // Bus released one cycle after done
    a_release: assert property (@(posedge wb_clock) disable iff (!arst_n)
        $past(cpu.done) |-> !cpu_data_oe)
        else mismatch("release after done", 8'h00, 8'(cpu_data_oe));

    task automatic bus_transfer(input logic we, input logic [15:0] adr,
                                input logic [7:0] wdat, output logic [7:0] rdat);
        int n;
        int acks_before;
        @(posedge wb_clock);
        wb_req <= '{adr: adr, dat: wdat, we: we, cyc: 1'b1, stb: 1'b1};
        acks_before = ack_count;
        n = 0;
        do begin
            @(negedge wb_clock);                       // Sample between edges
            n++;
        end while (!wb_rsp.ack && n < ACK_TIMEOUT);
        if (!wb_rsp.ack) begin
            abort_with($sformatf("Wishbone access to 0x%04h got no ack", adr));
        end
        rdat = wb_rsp.dat;
        repeat (2) @(posedge wb_clock);                // Strobe stays up past the ack
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        @(posedge wb_clock);                           // Room for a repeated ack to show
        @(negedge wb_clock);
        assert (ack_count == acks_before + 1)
            else mismatch($sformatf("ack count at 0x%04h", adr), 8'(acks_before + 1),
                          8'(ack_count));
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [7:0] dat);
        logic [7:0] unused_rd;
        bus_transfer(1'b1, adr, dat, unused_rd);
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [7:0] dat);
        bus_transfer(1'b0, adr, 8'h00, dat);
    endtask

    task automatic read_expect(input string name, input logic [15:0] adr, input logic [7:0] exp);
        logic [7:0] got;
        wb_read(adr, got);
        assert (got == exp) else mismatch(name, exp, got);
    endtask

    // Rows past ROW_COUNT do not exist, model keeps 0xFF there
    task automatic row_store(input logic [3:0] idx, input logic [7:0] val);
        wb_write(KBD_BASE | {12'h000, idx}, val);
        if ({1'b0, idx} < 5'(ROW_COUNT)) begin
            model[idx] = val;
        end
    endtask

    // Valid, three held cycles, then done
    task automatic pia_cycle(input logic [1:0] rs, input logic we, input logic [7:0] dat);
        @(posedge wb_clock);
        cpu <= '{rs: rs, cs: 1'b1, we: we, dat: dat, valid: 1'b1, done: 1'b0};
        @(posedge wb_clock);
        cpu.valid <= 1'b0;
        repeat (3) @(posedge wb_clock);
        cpu.done <= 1'b1;
        @(posedge wb_clock);
        cpu <= '0;
    endtask

    task automatic cpu_write_porta(input logic [7:0] v);
        pia_cycle(PIA_PORTA, 1'b1, v);
        exp_sel = v[3:0];
    endtask

    task automatic cpu_read_portb();
        rd_open = 1'b1;
        pia_cycle(PIA_PORTB, 1'b0, 8'h00);
        rd_open = 1'b0;                                // Release edge still sees it open
    endtask

    initial begin
        logic [3:0] idx;
        wb_req  = '0;
        cpu     = '0;
        arst_n  = 1'b0;
        exp_en  = 1'b1;
        exp_sel = 4'd0;
        rd_open = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model[i] = 8'hFF;
        end
        repeat (8) @(posedge wb_clock);
        arst_n <= 1'b1;
        @(negedge wb_clock);
        assert (!cpu_data_oe) else mismatch("oe after reset", 8'h00, 8'(cpu_data_oe));

        read_expect("CTRL after reset", KBD_BASE | 16'(REG_CTRL), 8'h01);
        for (int i = 0; i < 16; i++) begin
            read_expect("row after reset", KBD_BASE | 16'(i), 8'hFF);
        end
        read_expect("ROW after reset", KBD_BASE | 16'(REG_ROW), 8'h00);

        // Random matrix contents
        for (int i = 0; i < 24; i++) begin
            rng = xorshift(rng);
            idx = 4'(rng % 32'd10);
            row_store(idx, rng[23:16]);
        end
        for (int i = 0; i < ROW_COUNT; i++) begin
            read_expect("row readback", KBD_BASE | 16'(i), model[i]);
        end
        row_store(4'd12, 8'h00);
        read_expect("row 12 ignored", KBD_BASE | 16'h000C, 8'hFF);

        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            cpu_write_porta(rng[7:0]);
            read_expect("ROW after port A write", KBD_BASE | 16'(REG_ROW), {4'h0, rng[3:0]});
        end

        // One pressed row, one idle row, then the whole matrix
        row_store(4'd3, 8'hEF);
        row_store(4'd5, 8'hFF);
        cpu_write_porta(8'h03);
        cpu_read_portb();
        cpu_write_porta(8'h05);
        cpu_read_portb();
        for (int i = 0; i < ROW_COUNT; i++) begin
            cpu_write_porta(8'(i));
            cpu_read_portb();
        end

        wb_write(KBD_BASE | 16'(REG_CTRL), 8'h00);
        exp_en = 1'b0;
        cpu_write_porta(8'h03);
        cpu_read_portb();                              // Pressed row, intercept off
        wb_write(KBD_BASE | 16'(REG_CTRL), 8'h01);
        exp_en = 1'b1;
        read_expect("CTRL re-enabled", KBD_BASE | 16'(REG_CTRL), 8'h01);
        row_store(4'd11, 8'h00);
        cpu_write_porta(8'h0B);
        cpu_read_portb();
        wb_write(KBD_BASE | 16'(REG_ROW), 8'h07);      // Read-only
        read_expect("ROW write ignored", KBD_BASE | 16'(REG_ROW), 8'h0B);

        read_expect("unmapped in window", KBD_BASE | 16'h0020, 8'hFF);
        read_expect("outside window", 16'h1234, 8'hFF);

        repeat (4) @(posedge wb_clock);
        $display("TEST PASSED");
        $finish;
    end

endmodule
